// ==== Makefile ====
SIM = obj_dir/Vtb_cpu_subsystem

all: run

$(SIM): build.f $(wildcard verilog/*.sv verilog/*.svh verif/*.sv)
	verilator --binary --timing --assert --top-module tb_cpu_subsystem -f build.f

run: $(SIM)
	./$(SIM) > sim.log 2>&1 || true
	cat sim.log
	@if grep -q "Something failed" sim.log; then exit 1; fi
	@grep -q "Everything OK" sim.log

clean:
	rm -rf obj_dir sim.log

.PHONY: all run clean

// ==== build.f ====
+incdir+verilog
verilog/core_pkg.sv
verilog/bus_pkg.sv
verilog/regfile.sv
verilog/mini_core.sv
verilog/mem_port_splitter.sv
verilog/cpu_subsystem.sv
verif/tb_cpu_subsystem.sv

// ==== verif/tb_cpu_subsystem.sv ====
`timescale 1ns/1ns
`include "cpu_consts.svh"

module tb_cpu_subsystem;

   import core_pkg::*;
   import bus_pkg::*;

   localparam int STOP_NONE = 0;
   localparam int STOP_HALT = 1;
   localparam int STOP_TRAP = 2;

   logic               clk = 1'b0;
   logic               reset = 1'b1;
   logic               i_valid;
   logic [`ADDR_W-1:0] i_addr;
   logic               i_ready = 1'b0;
   logic [`DATA_W-1:0] i_data = '0;
   logic               d_valid;
   logic [`ADDR_W-1:0] d_addr;
   logic [`DATA_W-1:0] d_wdata;
   strb_t              d_wstrb;
   logic               d_ready = 1'b0;
   logic [`DATA_W-1:0] d_rdata = '0;
   logic               halted;
   logic               trap;

   // 64-word memories indexed by address bits 7:2
   logic [`DATA_W-1:0] imem [64];
   logic [`DATA_W-1:0] dmem [64];
   logic [`DATA_W-1:0] ref_mem [64];
   logic [5:0]         emit_ptr;
   logic [15:0]        lfsr = 16'd86;
   logic               i_busy = 1'b0;
   logic               d_busy = 1'b0;
   logic [1:0]         i_wait = '0;
   logic [1:0]         d_wait = '0;

   // expected data writes in bus order
   logic [`ADDR_W-1:0] exp_addr [$];
   logic [`DATA_W-1:0] exp_data [$];
   strb_t              exp_strb [$];
   int                 writes_seen = 0;
   int                 checks = 0;
   int                 errors = 0;
   int                 compare_checks = 0;
   int                 compare_errors = 0;
   int                 want_stop;

   cpu_subsystem DUT (.*);

   initial
   begin
      forever
      begin
         #20 clk = ~clk;
      end
   end

   function automatic logic next_random_bit();
      logic out;
      out = lfsr[0];
      lfsr = lfsr >> 1;
      if (out)
         lfsr = lfsr ^ 16'hB400;
      return out;
   endfunction

   function automatic logic [1:0] pick_wait();
      logic [1:0] w;
      w[0] = next_random_bit();
      w[1] = next_random_bit();
      return w;
   endfunction

   function automatic logic [`DATA_W-1:0] preset_word(logic [5:0] idx);
      return 32'h1234_0000 + {26'd0, idx} * 32'h0001_0101;
   endfunction

   function automatic logic [31:0] enc_r(opcode_t op, logic [3:0] rd, logic [3:0] rs1,
                                         logic [3:0] rs2);
      return {op, rd, rs1, rs2, 16'h0000};
   endfunction

   // bits 19:16 stay zero in the immediate form
   function automatic logic [31:0] enc_i(opcode_t op, logic [3:0] rd, logic [3:0] rs1,
                                         logic [15:0] imm);
      return {op, rd, rs1, 4'h0, imm};
   endfunction

   task automatic append_instr(logic [31:0] w);
      imem[emit_ptr] = w;
      emit_ptr = emit_ptr + 6'd1;
   endtask

   // unused words decode as HALT
   task automatic clear_program();
      for (int k = 0; k < 64; k++)
         imem[k[5:0]] = {OP_HALT, 22'd0, k[5:0]};
      emit_ptr = '0;
   endtask

   task automatic load_main_program();
      clear_program();
      append_instr(enc_i(OP_LW, 4'd1, 4'd0, 16'd0));
      append_instr(enc_i(OP_LW, 4'd2, 4'd0, 16'd4));
      append_instr(enc_r(OP_ADD, 4'd3, 4'd1, 4'd2));
      append_instr(enc_i(OP_SW, 4'd3, 4'd0, 16'd32));
      append_instr(enc_r(OP_SUB, 4'd4, 4'd1, 4'd2));
      append_instr(enc_i(OP_SW, 4'd4, 4'd0, 16'd36));
      append_instr(enc_r(OP_AND, 4'd5, 4'd1, 4'd2));
      append_instr(enc_i(OP_SW, 4'd5, 4'd0, 16'd40));
      append_instr(enc_r(OP_OR, 4'd6, 4'd1, 4'd2));
      append_instr(enc_i(OP_SW, 4'd6, 4'd0, 16'd44));
      // minus 100
      append_instr(enc_i(OP_ADDI, 4'd7, 4'd3, 16'hFF9C));
      append_instr(enc_i(OP_SW, 4'd7, 4'd0, 16'd48));
      // one byte store per lane
      append_instr(enc_i(OP_ADDI, 4'd8, 4'd0, 16'h07A5));
      append_instr(enc_i(OP_SB, 4'd8, 4'd0, 16'd64));
      append_instr(enc_i(OP_ADDI, 4'd8, 4'd8, 16'd1));
      append_instr(enc_i(OP_SB, 4'd8, 4'd0, 16'd69));
      append_instr(enc_i(OP_ADDI, 4'd8, 4'd8, 16'd1));
      append_instr(enc_i(OP_SB, 4'd8, 4'd0, 16'd74));
      append_instr(enc_i(OP_ADDI, 4'd8, 4'd8, 16'd1));
      append_instr(enc_i(OP_SB, 4'd8, 4'd0, 16'd79));
      // loop of three passes at word 21
      append_instr(enc_i(OP_ADDI, 4'd9, 4'd0, 16'd3));
      append_instr(enc_r(OP_ADD, 4'd10, 4'd10, 4'd1));
      append_instr(enc_i(OP_ADDI, 4'd9, 4'd9, 16'hFFFF));
      append_instr(enc_i(OP_SW, 4'd10, 4'd0, 16'd80));
      append_instr(enc_i(OP_BEQ, 4'd9, 4'd0, 16'd2));
      append_instr(enc_i(OP_BEQ, 4'd0, 4'd0, 16'hFFFC));
      append_instr(enc_i(OP_LW, 4'd11, 4'd0, 16'd80));
      append_instr(enc_i(OP_ADDI, 4'd11, 4'd11, 16'd5));
      append_instr(enc_i(OP_SW, 4'd11, 4'd0, 16'd84));
      // r1 and r2 differ so this falls through
      append_instr(enc_i(OP_BEQ, 4'd1, 4'd2, 16'd2));
      append_instr(enc_i(OP_SW, 4'd11, 4'd0, 16'd88));
      append_instr(enc_i(OP_HALT, 4'd0, 4'd0, 16'd0));
   endtask

   task automatic load_trap_program();
      clear_program();
      append_instr(enc_i(OP_ADDI, 4'd1, 4'd0, 16'h0033));
      append_instr(enc_i(OP_SW, 4'd1, 4'd0, 16'd96));
      append_instr(32'hF000_0000);
   endtask

   // instruction set model that fills exp_* and ref_mem
   function automatic int interpret_program();
      logic [31:0] regs [16];
      logic [31:0] pc;
      logic [31:0] pc_next;
      logic [31:0] w;
      logic [31:0] imm;
      logic [31:0] ea;
      logic [31:0] a;
      logic [31:0] b;
      logic [31:0] d;
      logic [31:0] res;
      logic        wr;
      logic [1:0]  lane;
      exp_addr.delete();
      exp_data.delete();
      exp_strb.delete();
      for (int k = 0; k < 64; k++)
         ref_mem[k[5:0]] = preset_word(k[5:0]);
      for (int k = 0; k < 16; k++)
         regs[k[3:0]] = '0;
      pc = '0;
      for (int step = 0; step < 2000; step++)
      begin
         w = imem[pc[7:2]];
         imm = {{16{w[15]}}, w[15:0]};
         a = regs[w[23:20]];
         b = regs[w[19:16]];
         d = regs[w[27:24]];
         ea = a + imm;
         res = '0;
         wr = 1'b0;
         pc_next = pc + 32'd4;
         case (w[31:28])
            OP_ADD:
            begin
               res = a + b;
               wr = 1'b1;
            end
            OP_SUB:
            begin
               res = a - b;
               wr = 1'b1;
            end
            OP_AND:
            begin
               res = a & b;
               wr = 1'b1;
            end
            OP_OR:
            begin
               res = a | b;
               wr = 1'b1;
            end
            OP_ADDI:
            begin
               res = a + imm;
               wr = 1'b1;
            end
            OP_LW:
            begin
               res = ref_mem[ea[7:2]];
               wr = 1'b1;
            end
            OP_SW:
            begin
               if (ea[1:0] != 2'b00)
                  return STOP_TRAP;
               ref_mem[ea[7:2]] = d;
               exp_addr.push_back(ea);
               exp_data.push_back(d);
               exp_strb.push_back(4'b1111);
            end
            OP_SB:
            begin
               lane = ea[1:0];
               ref_mem[ea[7:2]][{lane, 3'b000} +: 8] = d[7:0];
               exp_addr.push_back(ea);
               exp_data.push_back({4{d[7:0]}});
               exp_strb.push_back(strb_t'(4'b0001 << lane));
            end
            OP_BEQ:
            begin
               if (d == a)
                  pc_next = pc + (imm << 2);
            end
            OP_HALT: return STOP_HALT;
            default: return STOP_TRAP;
         endcase
         if (wr && w[27:24] != 4'd0)
            regs[w[27:24]] = res;
         pc = pc_next;
      end
      return STOP_NONE;
   endfunction

   // both memories with random wait states and a data preset during reset
   always @(posedge clk)
   begin
      #1;
      i_ready = 1'b0;
      d_ready = 1'b0;
      if (reset)
      begin
         for (int k = 0; k < 64; k++)
            dmem[k[5:0]] = preset_word(k[5:0]);
      end
      if (i_valid)
      begin
         if (!i_busy)
         begin
            i_busy = 1'b1;
            i_wait = pick_wait();
         end
         if (i_wait == 2'd0)
         begin
            i_ready = 1'b1;
            i_busy  = 1'b0;
            i_data  = imem[i_addr[7:2]];
         end
         else
            i_wait = i_wait - 2'd1;
      end
      if (d_valid)
      begin
         if (!d_busy)
         begin
            d_busy = 1'b1;
            d_wait = pick_wait();
         end
         if (d_wait == 2'd0)
         begin
            d_ready = 1'b1;
            d_busy  = 1'b0;
            if (d_wstrb == '0)
               d_rdata = dmem[d_addr[7:2]];
            else
            begin
               for (int b = 0; b < 4; b++)
                  if (d_wstrb[b])
                     dmem[d_addr[7:2]][{b[1:0], 3'b000} +: 8] = d_wdata[{b[1:0], 3'b000} +: 8];
            end
         end
         else
            d_wait = d_wait - 2'd1;
      end
   end

   // write transfers against the reference list
   always @(negedge clk)
   begin
      if (reset)
         writes_seen = 0;
      else
      begin
         if (i_valid && d_valid)
         begin
            $display("instruction and data requests were valid in the same cycle");
            compare_errors++;
         end
         if (d_valid && d_ready && d_wstrb != '0)
         begin
            compare_checks++;
            if (writes_seen >= exp_addr.size())
            begin
               $display("unexpected data write to address %h", d_addr);
               compare_errors++;
            end
            else
            begin
               if (d_addr !== exp_addr[writes_seen])
               begin
                  $display("mismatch d_addr: got %h expected %h", d_addr, exp_addr[writes_seen]);
                  compare_errors++;
               end
               if (d_wdata !== exp_data[writes_seen])
               begin
                  $display("mismatch d_wdata: got %h expected %h", d_wdata,
                           exp_data[writes_seen]);
                  compare_errors++;
               end
               if (d_wstrb !== exp_strb[writes_seen])
               begin
                  $display("mismatch d_wstrb: got %h expected %h", d_wstrb,
                           exp_strb[writes_seen]);
                  compare_errors++;
               end
            end
            writes_seen++;
         end
      end
   end

   task automatic run_program(int expect_stop);
      int n;
      repeat (2) @(posedge clk);
      #1;
      reset = 1'b0;
      checks++;
      if (i_valid || d_valid || halted || trap)
      begin
         $display("outputs not idle after reset");
         errors++;
      end
      n = 0;
      while (!i_valid && n < 20)
      begin
         @(posedge clk);
         #1;
         n++;
      end
      checks++;
      if (!i_valid)
      begin
         $display("no instruction fetch appeared after reset");
         errors++;
      end
      else if (i_addr !== 32'd0)
      begin
         $display("mismatch i_addr: got %h expected %h", i_addr, 32'd0);
         errors++;
      end
      n = 0;
      while (!halted && !trap && n < 4000)
      begin
         @(posedge clk);
         #1;
         n++;
      end
      checks++;
      if (!halted && !trap)
      begin
         $display("core did not stop within 4000 cycles");
         errors++;
      end
      else
      begin
         if (halted !== (expect_stop == STOP_HALT))
         begin
            $display("mismatch halted: got %h expected %h", halted, expect_stop == STOP_HALT);
            errors++;
         end
         if (trap !== (expect_stop == STOP_TRAP))
         begin
            $display("mismatch trap: got %h expected %h", trap, expect_stop == STOP_TRAP);
            errors++;
         end
      end
      // the core must stay quiet once stopped
      repeat (20)
      begin
         @(posedge clk);
         #1;
         if (i_valid || d_valid)
         begin
            $display("a bus request appeared after the core stopped");
            errors++;
         end
      end
      checks++;
      if (writes_seen != exp_addr.size())
      begin
         $display("saw %0d data writes but expected %0d", writes_seen, exp_addr.size());
         errors++;
      end
      for (int k = 0; k < 64; k++)
      begin
         checks++;
         if (dmem[k[5:0]] !== ref_mem[k[5:0]])
         begin
            $display("mismatch dmem[%0d]: got %h expected %h", k, dmem[k[5:0]],
                     ref_mem[k[5:0]]);
            errors++;
         end
      end
   endtask

   initial
   begin
      load_main_program();
      want_stop = interpret_program();
      if (want_stop != STOP_HALT)
      begin
         $display("reference model did not reach HALT in the main program");
         errors++;
      end
      run_program(STOP_HALT);
      reset = 1'b1;
      load_trap_program();
      want_stop = interpret_program();
      if (want_stop != STOP_TRAP)
      begin
         $display("reference model did not trap in the second program");
         errors++;
      end
      run_program(STOP_TRAP);
      $display("checks %0d, errors %0d", checks + compare_checks, errors + compare_errors);
      if (errors + compare_errors == 0)
         $display("Everything OK");
      else
         $display("Something failed");
      $finish;
   end

endmodule

// ==== verilog/bus_pkg.sv ====
`include "cpu_consts.svh"

package bus_pkg;

   // all zero means a read
   typedef logic [`STRB_W-1:0] strb_t;

   // which bus a unified-port request goes to
   typedef enum logic {
      TGT_DATA  = 1'b0,
      TGT_INSTR = 1'b1
   } target_t;

endpackage

// ==== verilog/core_pkg.sv ====
`include "cpu_consts.svh"

package core_pkg;

   // codes 10 to 15 are illegal
   typedef enum logic [3:0] {
      OP_ADD  = 4'h0,
      OP_SUB  = 4'h1,
      OP_AND  = 4'h2,
      OP_OR   = 4'h3,
      OP_ADDI = 4'h4,
      OP_LW   = 4'h5,
      OP_SW   = 4'h6,
      OP_SB   = 4'h7,
      OP_BEQ  = 4'h8,
      OP_HALT = 4'h9
   } opcode_t;

   typedef struct packed {
      opcode_t               opcode;
      logic [`REG_IDX_W-1:0] rd;
      logic [`REG_IDX_W-1:0] rs1;
      logic [`REG_IDX_W-1:0] rs2;
      logic [15:0]           unused;
   } r_form_t;

   // bits 19:16 sit where rs2 lives in the register form
   typedef struct packed {
      opcode_t                   opcode;
      logic [`REG_IDX_W-1:0]     rd;
      logic [`REG_IDX_W-1:0]     rs1;
      logic [`REG_IDX_W-1:0]     unused;
      logic signed [`IMM_W-1:0]  imm;
   } i_form_t;

   typedef union packed {
      r_form_t r;
      i_form_t i;
   } instr_t;

   typedef enum logic [1:0] {FETCH, EXEC, MEM, STOP} core_state_t;

endpackage

// ==== verilog/cpu_consts.svh ====
`ifndef CPU_CONSTS_SVH
`define CPU_CONSTS_SVH

// byte addresses
`define ADDR_W 32

// data and instruction word
`define DATA_W 32

// register file
`define REG_CNT 16
`define REG_IDX_W 4

// one strobe bit per byte lane
`define STRB_W 4

// immediate field of the instruction word
`define IMM_W 16

`endif

// ==== verilog/cpu_subsystem.sv ====
`timescale 1ns/1ns
`include "cpu_consts.svh"

module cpu_subsystem (
   input  logic               clk,
   input  logic               reset,
   output logic               i_valid,
   output logic [`ADDR_W-1:0] i_addr,
   input  logic               i_ready,
   input  logic [`DATA_W-1:0] i_data,
   output logic               d_valid,
   output logic [`ADDR_W-1:0] d_addr,
   output logic [`DATA_W-1:0] d_wdata,
   output bus_pkg::strb_t     d_wstrb,
   input  logic               d_ready,
   input  logic [`DATA_W-1:0] d_rdata,
   output logic               halted,
   output logic               trap
);

   // unified core port
   logic               mem_valid;
   logic               mem_instr;
   logic [`ADDR_W-1:0] mem_addr;
   logic [`DATA_W-1:0] mem_wdata;
   bus_pkg::strb_t     mem_wstrb;
   logic               mem_ready;
   logic [`DATA_W-1:0] mem_rdata;

   mini_core u_core (
      .clk       (clk),
      .reset     (reset),
      .mem_valid (mem_valid),
      .mem_instr (mem_instr),
      .mem_addr  (mem_addr),
      .mem_wdata (mem_wdata),
      .mem_wstrb (mem_wstrb),
      .mem_ready (mem_ready),
      .mem_rdata (mem_rdata),
      .halted    (halted),
      .trap      (trap)
   );

   mem_port_splitter u_splitter (
      .clk       (clk),
      .reset     (reset),
      .mem_valid (mem_valid),
      .mem_instr (mem_instr),
      .mem_addr  (mem_addr),
      .mem_wdata (mem_wdata),
      .mem_wstrb (mem_wstrb),
      .mem_ready (mem_ready),
      .mem_rdata (mem_rdata),
      .i_valid   (i_valid),
      .i_addr    (i_addr),
      .i_ready   (i_ready),
      .i_data    (i_data),
      .d_valid   (d_valid),
      .d_addr    (d_addr),
      .d_wdata   (d_wdata),
      .d_wstrb   (d_wstrb),
      .d_ready   (d_ready),
      .d_rdata   (d_rdata)
   );

endmodule

// ==== verilog/mem_port_splitter.sv ====
`timescale 1ns/1ns
`include "cpu_consts.svh"

module mem_port_splitter (
   input  logic               clk,
   input  logic               reset,
   input  logic               mem_valid,
   input  logic               mem_instr,
   input  logic [`ADDR_W-1:0] mem_addr,
   input  logic [`DATA_W-1:0] mem_wdata,
   input  bus_pkg::strb_t     mem_wstrb,
   output logic               mem_ready,
   output logic [`DATA_W-1:0] mem_rdata,
   output logic               i_valid,
   output logic [`ADDR_W-1:0] i_addr,
   input  logic               i_ready,
   input  logic [`DATA_W-1:0] i_data,
   output logic               d_valid,
   output logic [`ADDR_W-1:0] d_addr,
   output logic [`DATA_W-1:0] d_wdata,
   output bus_pkg::strb_t     d_wstrb,
   input  logic               d_ready,
   input  logic [`DATA_W-1:0] d_rdata
);

   import bus_pkg::*;

   target_t tgt;
   logic    done;
   logic    bus_ack;

   assign tgt = target_t'(mem_instr);

   // done hides the request between the bus ready and the core ready
   assign i_valid = mem_valid && tgt == TGT_INSTR && !done;
   assign d_valid = mem_valid && tgt == TGT_DATA && !done;
   assign i_addr  = mem_addr;
   assign d_addr  = mem_addr;
   assign d_wdata = mem_wdata;
   assign d_wstrb = mem_wstrb;

   assign bus_ack = (i_valid && i_ready) || (d_valid && d_ready);

   always_ff @(posedge clk)
   begin
      if (reset)
      begin
         done      <= 1'b0;
         mem_ready <= 1'b0;
      end
      else
      begin
         mem_ready <= bus_ack;
         if (bus_ack)
            done <= 1'b1;
         else if (mem_ready || !mem_valid)
            done <= 1'b0;
      end
   end

   always_ff @(posedge clk)
   begin
      if (bus_ack)
         mem_rdata <= (tgt == TGT_INSTR) ? i_data : d_rdata;
   end

   assert property (@(posedge clk) disable iff (reset) !(i_valid && d_valid));

   // fetches from the core must be plain reads
   assert property (@(posedge clk) disable iff (reset) i_valid |-> mem_wstrb == '0);

endmodule

// ==== verilog/mini_core.sv ====
`timescale 1ns/1ns
`include "cpu_consts.svh"

module mini_core (
   input  logic               clk,
   input  logic               reset,
   output logic               mem_valid,
   output logic               mem_instr,
   output logic [`ADDR_W-1:0] mem_addr,
   output logic [`DATA_W-1:0] mem_wdata,
   output bus_pkg::strb_t     mem_wstrb,
   input  logic               mem_ready,
   input  logic [`DATA_W-1:0] mem_rdata,
   output logic               halted,
   output logic               trap
);

   import core_pkg::*;
   import bus_pkg::*;

   core_state_t           state;
   core_state_t           state_next;
   instr_t                ir;
   opcode_t               op;
   target_t               req_tgt;
   logic [`ADDR_W-1:0]    pc;
   logic [`ADDR_W-1:0]    pc_plus4;
   logic [`ADDR_W-1:0]    br_target;
   logic [`ADDR_W-1:0]    ea;
   logic [`ADDR_W-1:0]    daddr_q;
   logic [`DATA_W-1:0]    ra;
   logic [`DATA_W-1:0]    rb;
   logic [`DATA_W-1:0]    imm_ext;
   logic [`DATA_W-1:0]    alu_res;
   logic [`DATA_W-1:0]    wdata_q;
   logic [`DATA_W-1:0]    rf_wdata;
   logic [`REG_IDX_W-1:0] rb_idx;
   logic                  is_alu;
   logic                  misaligned;
   logic                  rf_we;
   strb_t                 strb_q;

   assign op      = ir.r.opcode;
   assign is_alu  = op inside {OP_ADD, OP_SUB, OP_AND, OP_OR};
   // second read port serves rs2 for register ops, rd for stores and BEQ
   assign rb_idx  = is_alu ? ir.r.rs2 : ir.i.rd;
   assign imm_ext = {{(`DATA_W - `IMM_W){ir.i.imm[`IMM_W-1]}}, ir.i.imm};

   assign pc_plus4   = pc + `ADDR_W'd4;
   assign br_target  = pc + (imm_ext << 2);
   assign ea         = ra + imm_ext;
   assign misaligned = ea[1:0] != 2'b00;

   regfile u_regfile (
      .clk      (clk),
      .reset    (reset),
      .rs1_idx  (ir.r.rs1),
      .rs2_idx  (rb_idx),
      .wr_en    (rf_we),
      .wr_idx   (ir.r.rd),
      .wr_data  (rf_wdata),
      .rs1_data (ra),
      .rs2_data (rb)
   );

   always_comb
   begin
      case (op)
         OP_ADD:  alu_res = ra + rb;
         OP_SUB:  alu_res = ra - rb;
         OP_AND:  alu_res = ra & rb;
         OP_OR:   alu_res = ra | rb;
         default: alu_res = ra + imm_ext;
      endcase
   end

   // loads write back in the cycle the data word arrives
   assign rf_we    = (state == EXEC && (is_alu || op == OP_ADDI)) ||
                     (state == MEM && mem_ready && op == OP_LW);
   assign rf_wdata = (state == MEM) ? mem_rdata : alu_res;

   always_comb
   begin
      state_next = state;
      case (state)
         FETCH:
         begin
            if (mem_ready)
               state_next = EXEC;
         end
         EXEC:
         begin
            if (is_alu || op == OP_ADDI || op == OP_BEQ)
               state_next = FETCH;
            else if (op == OP_LW || op == OP_SB)
               state_next = MEM;
            else if (op == OP_SW)
               state_next = misaligned ? STOP : MEM;
            else
               state_next = STOP;
         end
         MEM:
         begin
            if (mem_ready)
               state_next = FETCH;
         end
         default:
            state_next = STOP;
      endcase
   end

   always_ff @(posedge clk)
   begin
      if (reset)
      begin
         state     <= FETCH;
         pc        <= '0;
         mem_valid <= 1'b0;
         halted    <= 1'b0;
         trap      <= 1'b0;
      end
      else
      begin
         state     <= state_next;
         mem_valid <= state_next == FETCH || state_next == MEM;
         if (state == EXEC)
         begin
            if (op == OP_BEQ)
               pc <= (ra == rb) ? br_target : pc_plus4;
            else if (op == OP_HALT)
               halted <= 1'b1;
            else if (state_next == STOP)
               trap <= 1'b1;
            else
               pc <= pc_plus4;
         end
      end
   end

   // instruction and data request payload
   always_ff @(posedge clk)
   begin
      if (state == FETCH && mem_ready)
         ir <= mem_rdata;
      if (state == EXEC)
      begin
         daddr_q <= ea;
         if (op == OP_SB)
         begin
            wdata_q <= {4{rb[7:0]}};
            strb_q  <= strb_t'(4'b0001 << ea[1:0]);
         end
         else
         begin
            wdata_q <= rb;
            strb_q  <= (op == OP_SW) ? 4'b1111 : 4'b0000;
         end
      end
   end

   assign req_tgt   = (state == MEM) ? TGT_DATA : TGT_INSTR;
   assign mem_instr = req_tgt == TGT_INSTR;
   assign mem_addr  = (req_tgt == TGT_INSTR) ? pc : daddr_q;
   assign mem_wdata = wdata_q;
   assign mem_wstrb = (req_tgt == TGT_DATA) ? strb_q : '0;

   assert property (@(posedge clk) disable iff (reset)
      mem_valid && !mem_ready |=> mem_valid && $stable(mem_instr) && $stable(mem_addr) &&
                                  $stable(mem_wdata) && $stable(mem_wstrb));

   assert property (@(posedge clk) disable iff (reset) !(halted && trap));

endmodule

// ==== verilog/regfile.sv ====
`timescale 1ns/1ns
`include "cpu_consts.svh"

module regfile (
   input  logic                  clk,
   input  logic                  reset,
   input  logic [`REG_IDX_W-1:0] rs1_idx,
   input  logic [`REG_IDX_W-1:0] rs2_idx,
   input  logic                  wr_en,
   input  logic [`REG_IDX_W-1:0] wr_idx,
   input  logic [`DATA_W-1:0]    wr_data,
   output logic [`DATA_W-1:0]    rs1_data,
   output logic [`DATA_W-1:0]    rs2_data
);

   logic [`DATA_W-1:0] regs [`REG_CNT];

   assign rs1_data = regs[rs1_idx];
   assign rs2_data = regs[rs2_idx];

   // r0 is never written so it stays at its reset value
   always_ff @(posedge clk)
   begin
      if (reset)
      begin
         for (int i = 0; i < `REG_CNT; i++)
         begin
            regs[i] <= '0;
         end
      end
      else if (wr_en && wr_idx != '0)
      begin
         regs[wr_idx] <= wr_data;
      end
   end

endmodule
